//--- hw/bob_config.svh
`ifndef BOB_CONFIG_SVH
`define BOB_CONFIG_SVH

// ------------------------------
// 720x480p output timing
// ------------------------------
`define BOB_H_ACTIVE  720
`define BOB_H_FP      16
`define BOB_H_SYNC    62
`define BOB_H_BP      60
`define BOB_H_TOTAL   858

`define BOB_V_ACTIVE  480
`define BOB_V_FP      9
`define BOB_V_SYNC    6
`define BOB_V_BP      30
`define BOB_V_TOTAL   525

// ------------------------------
// line buffers and descriptor queue
// ------------------------------
`define BOB_NUM_BUFS  8
`define BOB_BUF_BITS  3
`define BOB_X_BITS    10

`define BOB_Q_DEPTH   16
`define BOB_Q_BITS    4

// drift correction: drop one line per slot while above this fill level
`define BOB_HIGH_WM   12
`define BOB_SAFE_LINE 456

`endif

//--- hw/bob_pkg.sv
`include "bob_config.svh"

package bob_pkg;

    // one stored camera line, as queued for display
    typedef struct packed {
        logic [`BOB_BUF_BITS-1:0] buf_idx;
        logic                     field_start;
    } line_desc_t;

    // registered output timing, one word per pixel clock
    typedef struct packed {
        logic [`BOB_X_BITS-1:0] x;
        logic                   de;
        logic                   hsync;              // active low
        logic                   vsync;              // active low
        logic                   line_start;
        logic                   active_line_start;
        logic                   drift_slot;         // pixel 0 of a late vblank line
    } vid_timing_t;

    // bob phase: first or second showing of a camera line
    typedef enum logic [0:0] {
        PHASE_FIRST  = 1'b0,
        PHASE_REPEAT = 1'b1
    } bob_phase_e;

    // per line decision of the scheduler
    typedef enum logic [1:0] {
        ACT_ADVANCE = 2'd0,
        ACT_REPEAT  = 2'd1,
        ACT_HOLD    = 2'd2,
        ACT_DROP    = 2'd3
    } line_act_e;

endpackage

//--- hw/video_timing.sv
`timescale 1ns/1ps
`include "bob_config.svh"

module video_timing (
    input  logic                 pix_clk,
    input  logic                 resetn,
    output bob_pkg::vid_timing_t timing
);
    import bob_pkg::*;

    localparam int V_BITS = $clog2(`BOB_V_TOTAL);

    localparam logic [`BOB_X_BITS-1:0] H_LAST = `BOB_X_BITS'(`BOB_H_TOTAL - 1);
    localparam logic [`BOB_X_BITS-1:0] H_ACT  = `BOB_X_BITS'(`BOB_H_ACTIVE);
    localparam logic [`BOB_X_BITS-1:0] HS_BEG = `BOB_X_BITS'(`BOB_H_ACTIVE + `BOB_H_FP);
    localparam logic [`BOB_X_BITS-1:0] HS_END =
        `BOB_X_BITS'(`BOB_H_ACTIVE + `BOB_H_FP + `BOB_H_SYNC);

    localparam logic [V_BITS-1:0] V_LAST = V_BITS'(`BOB_V_TOTAL - 1);
    localparam logic [V_BITS-1:0] V_ACT  = V_BITS'(`BOB_V_ACTIVE);
    localparam logic [V_BITS-1:0] VS_BEG = V_BITS'(`BOB_V_ACTIVE + `BOB_V_FP);
    localparam logic [V_BITS-1:0] VS_END = V_BITS'(`BOB_V_ACTIVE + `BOB_V_FP + `BOB_V_SYNC);
    localparam logic [V_BITS-1:0] V_SAFE = V_BITS'(`BOB_SAFE_LINE);

    logic [`BOB_X_BITS-1:0] h_cnt;
    logic [V_BITS-1:0]      v_cnt;
    vid_timing_t            timing_n;

    // free running pixel and line counters
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // decode the counters into one timing word
    always_comb begin
        timing_n.x                 = h_cnt;
        timing_n.de                = (h_cnt < H_ACT) && (v_cnt < V_ACT);
        timing_n.hsync             = !((h_cnt >= HS_BEG) && (h_cnt < HS_END));
        timing_n.vsync             = !((v_cnt >= VS_BEG) && (v_cnt < VS_END));
        timing_n.line_start        = (h_cnt == '0);
        timing_n.active_line_start = (h_cnt == '0) && (v_cnt < V_ACT);
        // v_cnt never reaches V_TOTAL, so the upper bound holds by itself
        timing_n.drift_slot        = (h_cnt == '0) && (v_cnt >= V_SAFE) && (v_cnt >= V_ACT);
    end

    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            timing <= '{x: '0, de: 1'b0, hsync: 1'b1, vsync: 1'b1,
                        line_start: 1'b0, active_line_start: 1'b0, drift_slot: 1'b0};
        end else begin
            timing <= timing_n;
        end
    end

endmodule

//--- hw/line_capture.sv
`timescale 1ns/1ps
`include "bob_config.svh"

module line_capture (
    input  logic                      pix_clk,
    input  logic                      resetn,
    input  logic                      cam_line_valid,
    input  logic                      cam_y_valid,
    input  logic [7:0]                cam_y,
    input  logic                      cam_field_toggle,
    input  logic [`BOB_NUM_BUFS-1:0]  release_mask,
    output bob_pkg::line_desc_t       desc,
    output logic                      desc_valid,
    input  logic [`BOB_BUF_BITS-1:0]  rd_buf,
    input  logic [`BOB_X_BITS-1:0]    rd_x,
    output logic [7:0]                rd_data
);
    import bob_pkg::*;

    localparam logic [`BOB_X_BITS-1:0] X_END = `BOB_X_BITS'(`BOB_H_ACTIVE);

    logic [7:0]               line_mem [`BOB_NUM_BUFS][`BOB_H_ACTIVE];
    logic                     line_valid_q;
    logic                     toggle_q;
    logic                     field_pend;
    logic                     field_cur;
    logic [`BOB_NUM_BUFS-1:0] free_map;
    logic [`BOB_BUF_BITS-1:0] wr_buf;
    logic [`BOB_X_BITS-1:0]   wr_x;
    logic                     drop_line;
    logic                     line_rise;
    logic                     line_fall;
    logic                     field_edge;
    logic                     alloc_ok;
    logic [`BOB_BUF_BITS-1:0] alloc_idx;
    logic [`BOB_BUF_BITS-1:0] buf_eff;
    logic [`BOB_X_BITS-1:0]   x_eff;
    logic                     drop_eff;
    logic                     pix_ok;

    assign line_rise  = cam_line_valid && !line_valid_q;
    assign line_fall  = !cam_line_valid && line_valid_q;
    assign field_edge = cam_field_toggle ^ toggle_q;

    // lowest free buffer wins
    always_comb begin
        alloc_ok  = 1'b0;
        alloc_idx = '0;
        for (int i = `BOB_NUM_BUFS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_ok  = 1'b1;
                alloc_idx = `BOB_BUF_BITS'(i);
            end
        end
    end

    // first byte may come with the rising edge itself
    assign buf_eff  = line_rise ? alloc_idx : wr_buf;
    assign x_eff    = line_rise ? '0 : wr_x;
    assign drop_eff = line_rise ? !alloc_ok : drop_line;
    assign pix_ok   = cam_line_valid && cam_y_valid && !drop_eff && (x_eff < X_END);

    // ------------------------------
    // line control and free map
    // ------------------------------
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            line_valid_q <= 1'b0;
            toggle_q     <= 1'b0;
            field_pend   <= 1'b0;
            field_cur    <= 1'b0;
            free_map     <= '1;
            wr_buf       <= '0;
            wr_x         <= '0;
            drop_line    <= 1'b0;
            desc_valid   <= 1'b0;
            desc         <= '0;
        end else begin
            line_valid_q <= cam_line_valid;
            toggle_q     <= cam_field_toggle;
            if (field_edge && !line_rise) field_pend <= 1'b1;
            if (line_rise) begin
                field_cur  <= field_pend || field_edge;
                field_pend <= 1'b0;
                wr_buf     <= alloc_idx;
                drop_line  <= !alloc_ok;
            end
            // released buffers return the same cycle a new one is taken
            if (line_rise && alloc_ok) free_map <= (free_map | release_mask) &
                                                  ~(`BOB_NUM_BUFS'(1) << alloc_idx);
            else free_map <= free_map | release_mask;
            wr_x       <= pix_ok ? x_eff + 1'b1 : x_eff;
            desc_valid <= line_fall && !drop_line;
            if (line_fall) desc <= '{buf_idx: wr_buf, field_start: field_cur};
        end
    end

    // ------------------------------
    // buffer memory
    // ------------------------------
    always_ff @(posedge pix_clk) begin
        if (pix_ok) line_mem[buf_eff][x_eff] <= cam_y;
        if (rd_x < X_END) rd_data <= line_mem[rd_buf][rd_x];
    end

endmodule

//--- hw/line_scheduler.sv
`timescale 1ns/1ps
`include "bob_config.svh"

module line_scheduler (
    input  logic                      pix_clk,
    input  logic                      resetn,
    input  bob_pkg::vid_timing_t      timing,
    input  bob_pkg::line_desc_t       desc,
    input  logic                      desc_valid,
    output logic [`BOB_NUM_BUFS-1:0]  release_mask,
    output logic [`BOB_BUF_BITS-1:0]  cur_buf,
    output logic                      cur_valid
);
    import bob_pkg::*;

    line_desc_t               q_mem [`BOB_Q_DEPTH];
    logic [`BOB_Q_BITS-1:0]   rd_ptr;
    logic [`BOB_Q_BITS-1:0]   wr_ptr;
    logic [`BOB_Q_BITS:0]     count_q;
    logic [`BOB_Q_BITS:0]     count_pop;
    line_desc_t               head;
    bob_phase_e               phase_q;
    bob_phase_e               phase_n;
    line_act_e                act;
    logic                     do_pop;
    logic                     do_push;
    logic [`BOB_NUM_BUFS-1:0] rel_n;
    logic [`BOB_BUF_BITS-1:0] buf_q;
    logic                     valid_q;

    assign head = q_mem[rd_ptr];

    // ------------------------------
    // per line decision
    // ------------------------------
    always_comb begin
        act       = ACT_HOLD;
        do_pop    = 1'b0;
        rel_n     = '0;
        cur_buf   = buf_q;
        cur_valid = valid_q;
        phase_n   = phase_q;

        if (timing.active_line_start) begin
            if (count_q == '0) begin
                act = (phase_q == PHASE_FIRST) ? ACT_HOLD : ACT_REPEAT;
            end else if (phase_q == PHASE_FIRST || head.field_start) begin
                // a field start cuts the repeat short
                act = ACT_ADVANCE;
            end else begin
                act = ACT_REPEAT;
            end
        end else if (timing.drift_slot && count_q > `BOB_HIGH_WM) begin
            act = ACT_DROP;
        end

        case (act)
            ACT_ADVANCE: begin
                do_pop    = 1'b1;
                if (valid_q) rel_n[buf_q] = 1'b1;
                cur_buf   = head.buf_idx;
                cur_valid = 1'b1;
                phase_n   = PHASE_REPEAT;
            end
            ACT_REPEAT: phase_n = PHASE_FIRST;
            ACT_DROP: begin
                do_pop             = 1'b1;
                rel_n[head.buf_idx] = 1'b1;
            end
            default: ;
        endcase

        // drift slots only occur in vblank, so the next frame starts fresh
        if (timing.drift_slot) phase_n = PHASE_FIRST;

        // incoming descriptor sees the queue after this cycle's pop
        count_pop = do_pop ? count_q - 1'b1 : count_q;
        do_push   = desc_valid && (count_pop != `BOB_Q_DEPTH);
        if (desc_valid && !do_push) rel_n[desc.buf_idx] = 1'b1;
    end

    // ------------------------------
    // queue and state registers
    // ------------------------------
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            rd_ptr       <= '0;
            wr_ptr       <= '0;
            count_q      <= '0;
            phase_q      <= PHASE_FIRST;
            buf_q        <= '0;
            valid_q      <= 1'b0;
            release_mask <= '0;
        end else begin
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            count_q      <= do_push ? count_pop + 1'b1 : count_pop;
            phase_q      <= phase_n;
            buf_q        <= cur_buf;
            valid_q      <= cur_valid;
            release_mask <= rel_n;
        end
    end

    always_ff @(posedge pix_clk) begin
        if (do_push) q_mem[wr_ptr] <= desc;
    end

endmodule

//--- hw/pixel_out.sv
`timescale 1ns/1ps
`include "bob_config.svh"

module pixel_out (
    input  logic                      pix_clk,
    input  logic                      resetn,
    input  bob_pkg::vid_timing_t      timing,
    input  logic [`BOB_BUF_BITS-1:0]  cur_buf,
    input  logic                      cur_valid,
    output logic [`BOB_BUF_BITS-1:0]  rd_buf,
    output logic [`BOB_X_BITS-1:0]    rd_x,
    input  logic [7:0]                rd_data,
    output logic [7:0]                vid_y,
    output logic                      vid_de,
    output logic                      vid_hsync,
    output logic                      vid_vsync
);
    import bob_pkg::*;

    logic y_en;

    // read is issued alongside the registered timing
    assign rd_buf = cur_buf;
    assign rd_x   = timing.x;

    // controls delayed one stage to line up with rd_data
    always_ff @(posedge pix_clk or negedge resetn) begin
        if (!resetn) begin
            vid_de    <= 1'b0;
            vid_hsync <= 1'b1;
            vid_vsync <= 1'b1;
            y_en      <= 1'b0;
        end else begin
            vid_de    <= timing.de;
            vid_hsync <= timing.hsync;
            vid_vsync <= timing.vsync;
            y_en      <= timing.de && cur_valid;
        end
    end

    // black outside active video and before the first shown line
    assign vid_y = y_en ? rd_data : 8'h00;

endmodule

//--- hw/bob_top.sv
`timescale 1ns/1ps
`include "bob_config.svh"

module bob_top (
    input  logic       pix_clk,
    input  logic       resetn,
    input  logic       cam_line_valid,
    input  logic       cam_y_valid,
    input  logic [7:0] cam_y,
    input  logic       cam_field_toggle,
    output logic [7:0] vid_y,
    output logic       vid_de,
    output logic       vid_hsync,
    output logic       vid_vsync
);
    import bob_pkg::*;

    vid_timing_t              timing;
    line_desc_t               desc;
    logic                     desc_valid;
    logic [`BOB_NUM_BUFS-1:0] release_mask;
    logic [`BOB_BUF_BITS-1:0] cur_buf;
    logic                     cur_valid;
    logic [`BOB_BUF_BITS-1:0] rd_buf;
    logic [`BOB_X_BITS-1:0]   rd_x;
    logic [7:0]               rd_data;

    video_timing u_video_timing (
        .pix_clk (pix_clk),
        .resetn  (resetn),
        .timing  (timing)
    );

    line_capture u_line_capture (
        .pix_clk          (pix_clk),
        .resetn           (resetn),
        .cam_line_valid   (cam_line_valid),
        .cam_y_valid      (cam_y_valid),
        .cam_y            (cam_y),
        .cam_field_toggle (cam_field_toggle),
        .release_mask     (release_mask),
        .desc             (desc),
        .desc_valid       (desc_valid),
        .rd_buf           (rd_buf),
        .rd_x             (rd_x),
        .rd_data          (rd_data)
    );

    line_scheduler u_line_scheduler (
        .pix_clk      (pix_clk),
        .resetn       (resetn),
        .timing       (timing),
        .desc         (desc),
        .desc_valid   (desc_valid),
        .release_mask (release_mask),
        .cur_buf      (cur_buf),
        .cur_valid    (cur_valid)
    );

    pixel_out u_pixel_out (
        .pix_clk   (pix_clk),
        .resetn    (resetn),
        .timing    (timing),
        .cur_buf   (cur_buf),
        .cur_valid (cur_valid),
        .rd_buf    (rd_buf),
        .rd_x      (rd_x),
        .rd_data   (rd_data),
        .vid_y     (vid_y),
        .vid_de    (vid_de),
        .vid_hsync (vid_hsync),
        .vid_vsync (vid_vsync)
    );

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ps
`include "bob_config.svh"

module tb_checker (
    input  logic       pix_clk,
    input  logic       resetn,
    input  logic       cam_line_valid,
    input  logic       cam_y_valid,
    input  logic [7:0] cam_y,
    input  logic       cam_field_toggle,
    input  logic       slow_check,
    input  logic [7:0] vid_y,
    input  logic       vid_de,
    input  logic       vid_hsync,
    input  logic       vid_vsync,
    output int         err_timing,
    output int         err_data,
    output int         err_order,
    output int         shown_cnt
);
    localparam int HS_BEG = `BOB_H_ACTIVE + `BOB_H_FP;
    localparam int VS_BEG = `BOB_V_ACTIVE + `BOB_V_FP;

    // captured camera lines, 720 bytes per entry
    logic [7:0] cap_bytes [$];
    bit         cap_slow [$];
    bit         cap_field [$];
    logic [7:0] line_buf [`BOB_H_ACTIVE];
    logic [7:0] out_line [`BOB_H_ACTIVE];
    logic       lv_q = 1'b0;
    logic       tog_q = 1'b0;
    bit         fld_pend;
    bit         cur_fld;
    bit         cur_slow;
    int         cap_x;
    bit         synced;
    bit         shown_any;
    int         h;
    int         v;
    int         last_idx = -1;
    int         run;
    int         avail_lines;
    bit         exp_de;
    bit         exp_hs;
    bit         exp_vs;

    initial begin
        err_timing = 0;
        err_data   = 0;
        err_order  = 0;
        shown_cnt  = 0;
    end

    // ------------------------------
    // camera side model
    // ------------------------------
    always @(posedge pix_clk) begin
        if (resetn) begin
            if (cam_line_valid && !lv_q) begin
                cur_fld  = fld_pend || (cam_field_toggle != tog_q);
                fld_pend = 0;
                cap_x    = 0;
                cur_slow = slow_check;
            end else if (cam_field_toggle != tog_q) begin
                fld_pend = 1;
            end
            if (cam_line_valid && cam_y_valid && cap_x < `BOB_H_ACTIVE) begin
                line_buf[cap_x] = cam_y;
                cap_x++;
            end
            if (!cam_line_valid && lv_q) begin
                for (int x = 0; x < `BOB_H_ACTIVE; x++) cap_bytes.push_back(line_buf[x]);
                cap_slow.push_back(cur_slow);
                cap_field.push_back(cur_fld);
            end
            lv_q  = cam_line_valid;
            tog_q = cam_field_toggle;
        end
    end

    task automatic check_line(input int line_no);
        int  idx;
        int  k;
        bit  zero;
        bit  same;
        idx  = -1;
        zero = 1;
        for (int x = 0; x < `BOB_H_ACTIVE; x++) if (out_line[x] != 8'h00) zero = 0;
        if (!shown_any && zero) return;
        k = (last_idx < 0) ? 0 : last_idx;
        while (idx < 0 && k < cap_slow.size()) begin
            same = 1;
            for (int x = 0; x < `BOB_H_ACTIVE && same; x++)
                if (cap_bytes[k * `BOB_H_ACTIVE + x] != out_line[x]) same = 0;
            if (same) idx = k;
            k++;
        end
        if (idx < 0) begin
            err_data++;
            $display("output line %0d matches no captured line at or after the last one", line_no);
            return;
        end
        shown_any = 1;
        if (idx == last_idx) begin
            // past its two showings a slow line may only repeat while nothing newer is queued
            if (run >= 2 && cap_slow[idx] && avail_lines > idx + 1 && cap_slow[idx + 1]) begin
                err_order++;
                $display("camera line %0d held although line %0d was already stored",
                         idx, idx + 1);
            end
            run++;
        end else begin
            // one showing only allowed at a frame start or before a field start
            if (last_idx >= 0 && run == 1 && line_no != 0 && !cap_field[idx]) begin
                err_order++;
                $display("camera line %0d shown only once, next line %0d has no field start",
                         last_idx, idx);
            end
            if (last_idx >= 0 && cap_slow[last_idx] && cap_slow[idx] && idx != last_idx + 1) begin
                err_order++;
                $display("camera lines skipped between %0d and %0d while camera is slow",
                         last_idx, idx);
            end
            last_idx = idx;
            run      = 1;
            shown_cnt++;
        end
    endtask

    // ------------------------------
    // output side timing and data
    // ------------------------------
    always @(posedge pix_clk) begin
        if (resetn) begin
            if (!vid_de && vid_y != 8'h00) begin
                err_data++;
                $display("ERR vid_y exp 00 got %h", vid_y);
            end
            if (!synced && vid_de) begin
                synced = 1;
                h      = 0;
                v      = 0;
            end
            if (synced) begin
                exp_de = (h < `BOB_H_ACTIVE) && (v < `BOB_V_ACTIVE);
                exp_hs = !(h >= HS_BEG && h < HS_BEG + `BOB_H_SYNC);
                exp_vs = !(v >= VS_BEG && v < VS_BEG + `BOB_V_SYNC);
                if (vid_de != exp_de) begin
                    err_timing++;
                    $display("ERR vid_de exp %h got %h", exp_de, vid_de);
                end
                if (vid_hsync != exp_hs) begin
                    err_timing++;
                    $display("ERR vid_hsync exp %h got %h", exp_hs, vid_hsync);
                end
                if (vid_vsync != exp_vs) begin
                    err_timing++;
                    $display("ERR vid_vsync exp %h got %h", exp_vs, vid_vsync);
                end
                // lines stored this early are queued before the next line start
                if (h == `BOB_H_TOTAL - 8) avail_lines = cap_slow.size();
                if (h < `BOB_H_ACTIVE) out_line[h] = vid_y;
                if (h == `BOB_H_ACTIVE - 1 && v < `BOB_V_ACTIVE) check_line(v);
                if (h == `BOB_H_TOTAL - 1) begin
                    h = 0;
                    v = (v == `BOB_V_TOTAL - 1) ? 0 : v + 1;
                end else begin
                    h++;
                end
            end
        end
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ps
`include "bob_config.svh"

module tb_top;
    localparam longint FRAME_NS    = `BOB_H_TOTAL * `BOB_V_TOTAL * 20;
    localparam longint NEAR_END    = 2 * FRAME_NS;
    localparam longint SLOW_END    = 4 * FRAME_NS;
    localparam longint FAST_END    = 5 * FRAME_NS + FRAME_NS / 2;
    localparam longint WATCHDOG_NS = 6 * FRAME_NS + FRAME_NS;

    logic       pix_clk;
    logic       resetn;
    logic       cam_line_valid;
    logic       cam_y_valid;
    logic [7:0] cam_y;
    logic       cam_field_toggle;
    logic       slow_check;
    logic [7:0] vid_y;
    logic       vid_de;
    logic       vid_hsync;
    logic       vid_vsync;
    int         err_timing;
    int         err_data;
    int         err_order;
    int         shown_cnt;
    int         line_cnt;
    int         slow_lines;

    bob_top u_bob_top (
        .pix_clk          (pix_clk),
        .resetn           (resetn),
        .cam_line_valid   (cam_line_valid),
        .cam_y_valid      (cam_y_valid),
        .cam_y            (cam_y),
        .cam_field_toggle (cam_field_toggle),
        .vid_y            (vid_y),
        .vid_de           (vid_de),
        .vid_hsync        (vid_hsync),
        .vid_vsync        (vid_vsync)
    );

    tb_checker u_checker (
        .pix_clk (pix_clk), .resetn (resetn),
        .cam_line_valid (cam_line_valid), .cam_y_valid (cam_y_valid),
        .cam_y (cam_y), .cam_field_toggle (cam_field_toggle), .slow_check (slow_check),
        .vid_y (vid_y), .vid_de (vid_de), .vid_hsync (vid_hsync), .vid_vsync (vid_vsync),
        .err_timing (err_timing), .err_data (err_data), .err_order (err_order),
        .shown_cnt (shown_cnt)
    );

    initial begin
        pix_clk = 1'b0;
        forever #10 pix_clk = ~pix_clk;
    end

    task automatic step();
        @(posedge pix_clk);
        #2;
    endtask

    // one 720 byte camera line, byte 0 carries the sequence number
    task automatic send_line(input int gap);
        int x;
        if (line_cnt > 0 && line_cnt % 240 == 0) begin
            cam_field_toggle = ~cam_field_toggle;
            step();
        end
        x = 0;
        cam_line_valid = 1'b1;
        while (x < `BOB_H_ACTIVE) begin
            cam_y_valid = ($urandom % 8) != 0;
            cam_y       = (x == 0) ? 8'(line_cnt) : 8'($urandom);
            if (cam_y_valid) x++;
            step();
        end
        cam_line_valid = 1'b0;
        cam_y_valid    = 1'b0;
        line_cnt++;
        repeat (gap) step();
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("run timed out before the stimulus finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h8bc7));
        resetn           = 1'b0;
        cam_line_valid   = 1'b0;
        cam_y_valid      = 1'b0;
        cam_y            = 8'h00;
        cam_field_toggle = 1'b0;
        slow_check       = 1'b0;
        line_cnt         = 0;
        slow_lines       = 0;
        repeat (5) @(posedge pix_clk);
        #2;
        resetn = 1'b1;

        // camera near the output rate
        while ($time < NEAR_END) send_line(900 + $urandom % 200);
        // camera too slow, skip checks start once the queue has settled
        while ($time < SLOW_END) begin
            slow_check = (slow_lines >= 20);
            send_line(8000 + $urandom % 500);
            slow_lines++;
        end
        slow_check = 1'b0;
        // camera too fast
        while ($time < FAST_END) send_line(20 + $urandom % 40);

        repeat (20 * `BOB_H_TOTAL) step();
        $display("errors: timing %0d, data %0d, order %0d; lines shown %0d",
                 err_timing, err_data, err_order, shown_cnt);
        if (err_timing + err_data + err_order == 0 && shown_cnt > 0) begin
            $display("Test OK");
        end else begin
            if (shown_cnt == 0) $display("no camera line ever reached the output");
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+hw
hw/bob_pkg.sv
hw/video_timing.sv
hw/line_capture.sv
hw/line_scheduler.sv
hw/pixel_out.sv
hw/bob_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_top
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
